// ==== hw/noc_pkg.sv ====
// ----------------------------------------------------------
// NoC request path package
// Mesh geometry, node id and header flit types, and the
// fixed system address map used for destination lookup
// ----------------------------------------------------------
`default_nettype none

package noc_pkg;

  // Mesh dimensions in nodes
  localparam int unsigned MeshX = 4;
  localparam int unsigned MeshY = 4;

  // Coordinate widths follow the mesh size
  localparam int unsigned XWidth = $clog2(MeshX);
  localparam int unsigned YWidth = $clog2(MeshY);

  // Sequence number and output port vector widths
  localparam int unsigned SeqWidth = 4;
  localparam int unsigned NumPorts = 5;

  // Number of entries in the system address map
  localparam int unsigned NumSamRules = 6;

  typedef logic [31:0] addr_t;

  // Node coordinate pair
  typedef struct packed {
    logic [XWidth-1:0] x;
    logic [YWidth-1:0] y;
  } id_t;

  // Wildcard over one coordinate, a set bit matches either value
  typedef logic [1:0] mask_t;

  // Address window, end_addr is exclusive
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
    id_t   dst;
    mask_t mask_x;
    mask_t mask_y;
  } sam_rule_t;

  // This network interface sits at node (1,2)
  localparam id_t LocalId = '{x: 2'd1, y: 2'd2};

  // Rules are checked in index order, lowest index wins
  localparam sam_rule_t Sam [NumSamRules] = '{
    // Unicast windows of 64 KiB
    '{start_addr: 32'h0000_0000, end_addr: 32'h0001_0000,
      dst: '{x: 2'd0, y: 2'd0}, mask_x: 2'b00, mask_y: 2'b00},
    '{start_addr: 32'h0001_0000, end_addr: 32'h0002_0000,
      dst: '{x: 2'd3, y: 2'd0}, mask_x: 2'b00, mask_y: 2'b00},
    '{start_addr: 32'h0002_0000, end_addr: 32'h0003_0000,
      dst: '{x: 2'd1, y: 2'd2}, mask_x: 2'b00, mask_y: 2'b00},
    '{start_addr: 32'h0003_0000, end_addr: 32'h0004_0000,
      dst: '{x: 2'd2, y: 2'd3}, mask_x: 2'b00, mask_y: 2'b00},
    // Whole of row 1
    '{start_addr: 32'h1000_0000, end_addr: 32'h1001_0000,
      dst: '{x: 2'd0, y: 2'd1}, mask_x: 2'b11, mask_y: 2'b00},
    // Nodes (0,2) and (0,3)
    '{start_addr: 32'h2000_0000, end_addr: 32'h2001_0000,
      dst: '{x: 2'd0, y: 2'd2}, mask_x: 2'b00, mask_y: 2'b01}
  };

  // Translated request out of stage 1
  typedef struct packed {
    addr_t addr;
    id_t   dst;
    mask_t mask_x;
    mask_t mask_y;
    logic  err;
  } req_t;

  // Header flit
  typedef struct packed {
    id_t                 dst;
    id_t                 src;
    mask_t               mask_x;
    mask_t               mask_y;
    logic [SeqWidth-1:0] seq;
    logic                err;
    addr_t               addr;
  } hdr_t;

  // Bit positions inside a port set
  typedef enum int unsigned {
    L = 0,
    N = 1,
    E = 2,
    S = 3,
    W = 4
  } port_e;

  typedef logic [NumPorts-1:0] port_set_t;

endpackage

`default_nettype wire

// ==== hw/noc_id_translation.sv ====
// ----------------------------------------------------------
// Stage 1 of the request path
// Decodes the address against the system address map into a
// destination, multicast masks and a decode miss flag
// ----------------------------------------------------------
`default_nettype none

module noc_id_translation import noc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  valid_i,
  input  addr_t addr_i,
  output logic  valid_o,
  output req_t  req_o
);

  // One bit per rule, set when the address falls in its window
  logic [NumSamRules-1:0] hit;
  // Decoded request before the stage register
  req_t                   req_d;

  // All windows are compared in parallel
  always_comb begin
    for (int i = 0; i < NumSamRules; i++) begin
      hit[i] = (addr_i >= Sam[i].start_addr) && (addr_i < Sam[i].end_addr);
    end
  end

  // Priority pick
  always_comb begin
    // Miss fallback, stay local and flag the error
    req_d.addr   = addr_i;
    req_d.dst    = LocalId;
    req_d.mask_x = '0;
    req_d.mask_y = '0;
    req_d.err    = 1'b1;
    // Walk from the last rule down so the lowest hit is kept
    for (int i = NumSamRules - 1; i >= 0; i--) begin
      if (hit[i]) begin
        req_d.dst    = Sam[i].dst;
        req_d.mask_x = Sam[i].mask_x;
        req_d.mask_y = Sam[i].mask_y;
        req_d.err    = 1'b0;
      end
    end
  end

  // Stage valid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Payload only loads on a valid request
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      req_o <= req_d;
    end
  end

endmodule

`default_nettype wire

// ==== hw/noc_hdr_build.sv ====
// ----------------------------------------------------------
// Stage 2 of the request path
// Assembles the header flit with source id and a running
// per-request sequence number
// ----------------------------------------------------------
`default_nettype none

module noc_hdr_build import noc_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  input  req_t req_i,
  output logic valid_o,
  output hdr_t hdr_o
);

  // Next sequence number to hand out
  logic [SeqWidth-1:0] seq_q;
  // Header before the stage register
  hdr_t                hdr_d;

  always_comb begin
    hdr_d.dst    = req_i.dst;
    hdr_d.src    = LocalId;
    hdr_d.mask_x = req_i.mask_x;
    hdr_d.mask_y = req_i.mask_y;
    hdr_d.seq    = seq_q;
    hdr_d.err    = req_i.err;
    hdr_d.addr   = req_i.addr;
  end

  // Stage valid and a sequence counter that wraps after 15
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
      seq_q   <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        seq_q <= seq_q + SeqWidth'(1);
      end
    end
  end

  // Header register
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      hdr_o <= hdr_d;
    end
  end

endmodule

`default_nettype wire

// ==== hw/noc_xy_route.sv ====
// ----------------------------------------------------------
// Stage 3 of the request path
// Dimension ordered XY routing to a multi-hot output port set
// ----------------------------------------------------------
`default_nettype none

module noc_xy_route import noc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  hdr_t      hdr_i,
  output logic      valid_o,
  output hdr_t      hdr_o,
  output port_set_t ports_o
);

  // Bounds of the destination set per dimension
  logic [XWidth-1:0] min_x;
  logic [XWidth-1:0] max_x;
  logic [YWidth-1:0] min_y;
  logic [YWidth-1:0] max_y;
  // Some member sits in the local column
  logic              in_col;
  // Local row is covered inside that column
  logic              in_row;
  port_set_t         ports_d;

  // Wildcard bits go to 0 for the minimum and to 1 for the maximum
  assign min_x = hdr_i.dst.x & ~hdr_i.mask_x;
  assign max_x = hdr_i.dst.x | hdr_i.mask_x;
  assign min_y = hdr_i.dst.y & ~hdr_i.mask_y;
  assign max_y = hdr_i.dst.y | hdr_i.mask_y;

  // Match on all bits that are not wildcards
  assign in_col = ((hdr_i.dst.x ^ LocalId.x) & ~hdr_i.mask_x) == '0;
  assign in_row = ((hdr_i.dst.y ^ LocalId.y) & ~hdr_i.mask_y) == '0;

  always_comb begin
    ports_d = '0;
    if (hdr_i.err) begin
      // Undecodable requests stay at the local port
      ports_d[L] = 1'b1;
    end else begin
      // X first
      ports_d[E] = max_x > LocalId.x;
      ports_d[W] = min_x < LocalId.x;
      // Y only for members in our own column
      ports_d[N] = in_col && (max_y > LocalId.y);
      ports_d[S] = in_col && (min_y < LocalId.y);
      ports_d[L] = in_col && in_row;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Header and port set travel together
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      hdr_o   <= hdr_i;
      ports_o <= ports_d;
    end
  end

endmodule

`default_nettype wire

// ==== hw/noc_req_path.sv ====
// ----------------------------------------------------------
// Request injection path of the network interface
// Translation, header build and XY routing in three stages
// ----------------------------------------------------------
`default_nettype none

module noc_req_path import noc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  addr_t     addr_i,
  output logic      valid_o,
  output hdr_t      hdr_o,
  output port_set_t ports_o
);

  // Stage 1 to stage 2
  logic s1_valid;
  req_t s1_req;
  // Stage 2 to stage 3
  logic s2_valid;
  hdr_t s2_hdr;

  noc_id_translation i_id_translation (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .addr_i  (addr_i),
    .valid_o (s1_valid),
    .req_o   (s1_req)
  );

  noc_hdr_build i_hdr_build (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (s1_valid),
    .req_i   (s1_req),
    .valid_o (s2_valid),
    .hdr_o   (s2_hdr)
  );

  noc_xy_route i_xy_route (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (s2_valid),
    .hdr_i   (s2_hdr),
    .valid_o (valid_o),
    .hdr_o   (hdr_o),
    .ports_o (ports_o)
  );

endmodule

`default_nettype wire

// ==== tests/tb_noc_req_path.sv ====
// ----------------------------------------------------------
// Testbench for the NoC request path
// Replays requests from the stimulus file and checks header
// fields, port sets, sequence numbers and latency
// ----------------------------------------------------------
`default_nettype none

module tb_noc_req_path import noc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int         reset_cycles = 10;
  localparam int         latency      = 3;
  // Node (1,2) packed as {x,y}
  localparam logic [3:0] local_node   = 4'h6;
  localparam string      stim_path    = "tests/noc_stimulus.txt";

  logic      clk_i;
  logic      rst_n_i;
  logic      valid_i;
  addr_t     addr_i;
  logic      valid_o;
  hdr_t      hdr_o;
  port_set_t ports_o;

  // Stimulus table with one entry per data line
  string       names[$];
  logic [31:0] addrs[$];
  int          gaps[$];
  logic [3:0]  exp_dst[$];
  logic [3:0]  exp_mask[$];
  logic        exp_err[$];
  logic [4:0]  exp_ports[$];

  // Requests in flight, oldest first
  int          pend_idx[$];
  logic [3:0]  pend_seq[$];
  int          pend_cyc[$];

  logic [3:0]  next_seq;
  int          cycle;
  int          cycle_limit;
  int          error_count;
  int          pass_count;
  int          fail_count;
  int          sum_gaps;
  logic        load_ok;

  noc_req_path dut (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .addr_i  (addr_i),
    .valid_o (valid_o),
    .hdr_o   (hdr_o),
    .ports_o (ports_o)
  );

  always #2 clk_i = ~clk_i;

  // Cycle count and run limit
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle_limit > 0 && cycle >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d requests still in flight",
               cycle, pend_idx.size());
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic load_stimulus(output logic ok);
    int          fd;
    int          count;
    string       line;
    string       name;
    logic [31:0] addr;
    int          gap;
    logic [3:0]  dst;
    logic [3:0]  mask;
    logic        err;
    logic [4:0]  ports;
    ok = 1'b1;
    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", stim_path);
      ok = 1'b0;
      return;
    end
    while (!$feof(fd)) begin
      line  = "";
      count = $fgets(line, fd);
      // Skip blank lines and column notes
      if (count > 0 && line.len() > 2 && line.getc(0) != "#") begin
        count = $sscanf(line, "%s %h %d %h %h %b %b",
                        name, addr, gap, dst, mask, err, ports);
        if (count != 7) begin
          $display("Stimulus line could not be read: %s", line);
          ok = 1'b0;
        end else begin
          names.push_back(name);
          addrs.push_back(addr);
          gaps.push_back(gap);
          exp_dst.push_back(dst);
          exp_mask.push_back(mask);
          exp_err.push_back(err);
          exp_ports.push_back(ports);
        end
      end
    end
    $fclose(fd);
    if (names.size() == 0) begin
      $display("Stimulus file holds no tests");
      ok = 1'b0;
    end
  endtask

  task automatic report_test(input int idx, input int errs_before);
    if (error_count == errs_before) begin
      pass_count++;
      $display("PASS %s", names[idx]);
    end else begin
      fail_count++;
      $display("FAIL %s", names[idx]);
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic idle_cycle();
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;
  endtask

  task automatic send_request(input int idx);
    repeat (gaps[idx]) idle_cycle();
    @(posedge clk_i);
    #1;
    valid_i = 1'b1;
    addr_i  = addrs[idx];
    pend_idx.push_back(idx);
    pend_seq.push_back(next_seq);
    pend_cyc.push_back(cycle);
    next_seq = next_seq + 4'd1;
  endtask

  task automatic wait_drained();
    while (pend_idx.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  // A line named reset holds reset low for its gap in cycles
  task automatic mid_reset(input int idx);
    int errs_before;
    errs_before = error_count;
    idle_cycle();
    wait_drained();
    @(posedge clk_i);
    #1;
    rst_n_i = 1'b0;
    // Requests offered while in reset must not enter the pipeline
    valid_i = 1'b1;
    addr_i  = addrs[idx];
    repeat (gaps[idx]) @(posedge clk_i);
    #1;
    rst_n_i  = 1'b1;
    valid_i  = 1'b0;
    next_seq = '0;
    report_test(idx, errs_before);
  endtask

  task automatic check_output();
    int         idx;
    logic [3:0] seq;
    int         lat;
    int         errs_before;
    errs_before = error_count;
    idx = pend_idx.pop_front();
    seq = pend_seq.pop_front();
    lat = cycle - pend_cyc.pop_front();
    if (hdr_o.dst !== exp_dst[idx]) begin
      $display("MISMATCH %s dst expected %h actual %h", names[idx], exp_dst[idx], hdr_o.dst);
      error_count++;
    end
    if (hdr_o.src !== local_node) begin
      $display("MISMATCH %s src expected %h actual %h", names[idx], local_node, hdr_o.src);
      error_count++;
    end
    if ({hdr_o.mask_x, hdr_o.mask_y} !== exp_mask[idx]) begin
      $display("MISMATCH %s masks expected %h actual %h", names[idx], exp_mask[idx],
               {hdr_o.mask_x, hdr_o.mask_y});
      error_count++;
    end
    if (hdr_o.err !== exp_err[idx]) begin
      $display("MISMATCH %s err expected %b actual %b", names[idx], exp_err[idx], hdr_o.err);
      error_count++;
    end
    if (hdr_o.seq !== seq) begin
      $display("MISMATCH %s seq expected %0d actual %0d", names[idx], seq, hdr_o.seq);
      error_count++;
    end
    if (hdr_o.addr !== addrs[idx]) begin
      $display("MISMATCH %s addr expected %h actual %h", names[idx], addrs[idx], hdr_o.addr);
      error_count++;
    end
    if (ports_o !== exp_ports[idx]) begin
      $display("MISMATCH %s ports expected %b actual %b", names[idx], exp_ports[idx], ports_o);
      error_count++;
    end
    if (lat != latency) begin
      $display("MISMATCH %s latency expected %0d actual %0d", names[idx], latency, lat);
      error_count++;
    end
    report_test(idx, errs_before);
  endtask

  // Output monitor sampled on the falling edge
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      if (valid_o !== 1'b0) begin
        $display("valid_o is not low during reset");
        error_count++;
      end
    end else if (valid_o === 1'b1) begin
      if (pend_idx.size() == 0) begin
        $display("valid_o went high with no request in flight");
        error_count++;
      end else begin
        check_output();
      end
    end else if (valid_o !== 1'b0) begin
      $display("valid_o is unknown out of reset");
      error_count++;
    end
  end

  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    addr_i      = '0;
    next_seq    = '0;
    cycle       = 0;
    cycle_limit = 0;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    sum_gaps    = 0;
    load_stimulus(load_ok);
    if (!load_ok) begin
      $display("Test FAILED");
      $finish;
    end else begin
      foreach (gaps[i]) begin
        sum_gaps += gaps[i];
      end
      cycle_limit = reset_cycles + sum_gaps + names.size() + latency + 50;
      repeat (reset_cycles) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      foreach (names[i]) begin
        if (names[i] == "reset") begin
          mid_reset(i);
        end else begin
          send_request(i);
        end
      end
      idle_cycle();
      wait_drained();
      // A few quiet cycles to catch stray outputs
      repeat (latency) idle_cycle();
      if (pass_count + fail_count != names.size()) begin
        $display("Only %0d of %0d tests finished", pass_count + fail_count, names.size());
        error_count++;
      end
      $display("Tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, error_count);
      if (error_count == 0 && fail_count == 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tests/noc_stimulus.txt ====
# name addr(hex) gap(idle cycles before) dst(hex {x,y}) masks(hex {mask_x,mask_y}) err ports
# ports bits are W S E N L, a line named reset holds reset low for gap cycles
uni_node00     00001234 2  0 0 0 10000
uni_node30     00018000 1  c 0 0 00100
uni_local_lo   00020000 1  6 0 0 00001
uni_node23_hi  0003ffff 0  b 0 0 00100
mc_row1        10000040 1  1 c 0 11100
mc_col0        2000fff0 0  2 1 0 10000
miss_above     00040000 2  6 0 1 00001
miss_bound     10010000 0  6 0 1 00001
miss_high      deadbeef 0  6 0 1 00001
b2b_00         00000010 0  0 0 0 10000
b2b_01         00010010 0  c 0 0 00100
b2b_02         00020010 0  6 0 0 00001
b2b_03         00030010 0  b 0 0 00100
b2b_04         10000010 0  1 c 0 11100
b2b_05         20000010 0  2 1 0 10000
b2b_06         00050000 0  6 0 1 00001
b2b_07         0000ffff 0  0 0 0 10000
b2b_08         0001ffff 0  c 0 0 00100
b2b_09         1000ffff 0  1 c 0 11100
b2b_10         2000ffff 0  2 1 0 10000
b2b_11         0002ffff 0  6 0 0 00001
reset          00000000 10 0 0 0 00000
post_rst_0     00030000 3  b 0 0 00100
post_rst_1     10008000 0  1 c 0 11100
post_rst_2     20000000 0  2 1 0 10000
post_rst_3     ffffffff 0  6 0 1 00001

// ==== sim.f ====
hw/noc_pkg.sv
hw/noc_id_translation.sv
hw/noc_hdr_build.sv
hw/noc_xy_route.sv
hw/noc_req_path.sv
tests/tb_noc_req_path.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the request path testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_noc_req_path -Mdir obj_dir
./obj_dir/Vtb_noc_req_path > sim.log
cat sim.log

# The run only counts as passed when the log holds the pass line
if grep -qx "Test OK" sim.log; then
  exit 0
fi
exit 1
